//--- build.f
+incdir+tests
design/flappy_pkg.sv
design/game_fsm.sv
design/hit_tracker.sv
design/course_tuner.sv
design/pillar_lane.sv
design/score_keeper.sv
design/flappy_control_top.sv
tests/tb_flappy_control.sv

//--- run_sim.sh
#!/bin/sh
# compile with verilator, run, then scan the log for the result
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --timescale 1ns/1ns --top-module tb_flappy_control \
  -f build.f -o sim_flappy \
  && ./obj_dir/sim_flappy > sim.log 2>&1 \
  || echo "compile or run failed" >> sim.log
cat sim.log
grep -q ">>> FAIL" sim.log && exit 1
grep -q ">>> PASS" sim.log && exit 0 || exit 1

//--- tests/flappy_model.svh
`ifndef FLAPPY_MODEL_SVH
`define FLAPPY_MODEL_SVH

// expected dut outputs, one update per active clock edge
flappy_pkg::game_state_e exp_state;
logic exp_intro_valid;
logic exp_intro_type;
logic exp_flash;
logic exp_bird_visible;
int   exp_timer;
int   exp_life;
int   exp_gap;
int   exp_speed;
int   exp_h [2];
logic exp_valid [2];
logic exp_pass [2];
int   exp_score;
int   exp_high;

// decimal value to four bcd digits
function automatic logic [15:0] to_bcd(input int value);
  logic [15:0] digits;
  int          rest;
  digits = '0;
  rest   = value;
  for (int i = 0; i < 4; i++)
  begin
    digits[i*4 +: 4] = 4'(rest % 10);
    rest = rest / 10;
  end
  return digits;
endfunction

task automatic reset_model();
  exp_state        = flappy_pkg::WELCOME;
  exp_intro_valid  = 1'b0;
  exp_intro_type   = 1'b0;
  exp_flash        = 1'b0;
  exp_bird_visible = 1'b1;
  exp_timer        = 0;
  exp_life         = 0;
  exp_gap          = 178;
  exp_speed        = 2;
  exp_score        = 0;
  exp_high         = 0;
  for (int i = 0; i < 2; i++)
  begin
    exp_h[i]     = 0;
    exp_valid[i] = 1'b0;
    exp_pass[i]  = 1'b0;
  end
endtask

//////////////////////////////
// one clock edge of the game
//////////////////////////////
task automatic step_model(input flappy_pkg::buttons_t b, input logic c,
                          input flappy_pkg::pea_event_t p);
  flappy_pkg::game_state_e nxt_state;
  logic                    playing;
  logic                    in_init;
  logic                    hit;
  nxt_state = exp_state;
  playing   = (exp_state == flappy_pkg::NORMAL_MODE) || (exp_state == flappy_pkg::CHEAT_MODE);
  in_init   = (exp_state == flappy_pkg::INITIAL_GAME);
  hit       = (c || (p.get && p.kind == flappy_pkg::PEA_HARM)) && (exp_timer == 0)
              && (exp_state != flappy_pkg::DEAD);
  case (exp_state)
    flappy_pkg::WELCOME:
      if (b.up)
        nxt_state = flappy_pkg::INITIAL_GAME;
    flappy_pkg::INITIAL_GAME:
      nxt_state = flappy_pkg::NORMAL_MODE;
    flappy_pkg::NORMAL_MODE:
    begin
      if (b.choose2)
        nxt_state = flappy_pkg::CHEAT_MODE;
      else if (exp_life == 0)
        nxt_state = flappy_pkg::DEAD;
    end
    flappy_pkg::CHEAT_MODE:
      if (b.choose1)
        nxt_state = flappy_pkg::NORMAL_MODE;
    default:
      if (b.enter)
        nxt_state = flappy_pkg::WELCOME;
  endcase
  exp_intro_valid = (exp_state == flappy_pkg::WELCOME) || (exp_state == flappy_pkg::DEAD);
  exp_intro_type  = (exp_state == flappy_pkg::DEAD);
  // high score looks at last cycle's score
  if (exp_score > exp_high)
    exp_high = exp_score;
  if (exp_state == flappy_pkg::WELCOME)
    exp_score = 0;
  else if (playing && (exp_pass[0] || exp_pass[1]))
    exp_score = (exp_score + 1) % 10000;
  for (int i = 0; i < 2; i++)
  begin
    exp_pass[i] = playing && exp_valid[i] && (exp_h[i] >= exp_speed)
                  && (exp_h[i] > 100) && (exp_h[i] - exp_speed <= 100);
    if (in_init)
    begin
      exp_h[i]     = (i == 0) ? 50 : 224;
      exp_valid[i] = 1'b0;
    end
    else if (playing && exp_h[i] < exp_speed)
    begin
      exp_h[i]     = 350;
      exp_valid[i] = 1'b1;
    end
    else if (playing)
      exp_h[i] = exp_h[i] - exp_speed;
    else if (exp_state == flappy_pkg::WELCOME)
      exp_valid[i] = 1'b0;
  end
  exp_flash        = (exp_timer != 0) && (exp_timer < 10);
  exp_bird_visible = !((exp_timer != 0) && (exp_state != flappy_pkg::DEAD)
                       && (exp_timer[4:3] == 2'b00));
  if (in_init)
    exp_timer = 0;
  else if (hit)
    exp_timer = 1;
  else if (exp_timer == 200)
    exp_timer = 0;
  else if (exp_timer != 0)
    exp_timer++;
  if (in_init)
    exp_life = 5;
  else if (p.get && p.kind == flappy_pkg::PEA_LIFE && exp_life < 15)
    exp_life++;
  else if (hit && exp_state == flappy_pkg::NORMAL_MODE && exp_life > 0)
    exp_life--;
  if (in_init)
  begin
    exp_gap   = 178;
    exp_speed = 2;
  end
  else if (p.get && p.kind == flappy_pkg::PEA_WIDEN)
    exp_gap = (exp_gap + 50 > 228) ? 228 : exp_gap + 50;
  else if (p.get && p.kind == flappy_pkg::PEA_NARROW)
    exp_gap = (exp_gap - 50 < 128) ? 128 : exp_gap - 50;
  else if (p.get && p.kind == flappy_pkg::PEA_FAST)
    exp_speed = 3;
  else if (p.get && p.kind == flappy_pkg::PEA_SLOW)
    exp_speed = 2;
  exp_state = nxt_state;
endtask

`endif

//--- tests/tb_flappy_control.sv
`timescale 1ns/1ns

module tb_flappy_control;

  // button fields are choose1, choose2, up, enter
  localparam flappy_pkg::buttons_t   NO_PRESS    = 4'b0000;
  localparam flappy_pkg::buttons_t   PRESS_C1    = 4'b1000;
  localparam flappy_pkg::buttons_t   PRESS_C2    = 4'b0100;
  localparam flappy_pkg::buttons_t   PRESS_UP    = 4'b0010;
  localparam flappy_pkg::buttons_t   PRESS_ENTER = 4'b0001;
  localparam flappy_pkg::pea_event_t NO_PEA      = 4'b0000;

  logic                     clk = 1'b0;
  logic                     rst_n;
  flappy_pkg::buttons_t     buttons;
  logic                     crash;
  flappy_pkg::pea_event_t   pea;
  flappy_pkg::game_state_e  state;
  logic                     intro_valid;
  logic                     intro_type;
  logic                     flash;
  logic                     bird_visible;
  logic [3:0]               life;
  logic [9:0]               gap_width;
  flappy_pkg::pillar_view_t pillar0;
  flappy_pkg::pillar_view_t pillar1;
  flappy_pkg::score_t       score;
  logic [15:0]              lfsr;
  int                       best_score;

  `include "flappy_model.svh"

  flappy_control_top u_dut (
    .clk(clk), .rst_n(rst_n), .buttons(buttons), .crash(crash), .pea(pea),
    .state(state), .intro_valid(intro_valid), .intro_type(intro_type), .flash(flash),
    .bird_visible(bird_visible), .life(life), .gap_width(gap_width),
    .pillar0(pillar0), .pillar1(pillar1), .score(score)
  );

  always #50 clk = ~clk;

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic draw_bits(input int n, output logic [7:0] v);
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsr = lfsr_next(lfsr);
      v    = {v[6:0], lfsr[0]};
    end
  endtask

  //////////////////////////////
  // checking
  //////////////////////////////
  task automatic stop_with_failure();
    $display(">>> FAIL");
    $fatal(1, "simulation stopped at the first failure");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp)
    begin
      $display("ERR %s got=0x%0h exp=0x%0h", name, got, exp);
      stop_with_failure();
    end
  endtask

  task automatic check_outputs();
    check_value("state", 32'(state), 32'(exp_state));
    check_value("intro_valid", 32'(intro_valid), 32'(exp_intro_valid));
    check_value("intro_type", 32'(intro_type), 32'(exp_intro_type));
    check_value("flash", 32'(flash), 32'(exp_flash));
    check_value("bird_visible", 32'(bird_visible), 32'(exp_bird_visible));
    check_value("life", 32'(life), exp_life);
    check_value("gap_width", 32'(gap_width), exp_gap);
    check_value("pillar0.h", 32'(pillar0.h), exp_h[0]);
    check_value("pillar0.valid", 32'(pillar0.valid), 32'(exp_valid[0]));
    check_value("pillar1.h", 32'(pillar1.h), exp_h[1]);
    check_value("pillar1.valid", 32'(pillar1.valid), 32'(exp_valid[1]));
    check_value("score.current", 32'(score.current), 32'(to_bcd(exp_score)));
    check_value("score.high", 32'(score.high), 32'(to_bcd(exp_high)));
  endtask

  //////////////////////////////
  // stimulus
  //////////////////////////////
  task automatic run_cycle(input flappy_pkg::buttons_t b, input logic c,
                           input flappy_pkg::pea_event_t p);
    @(posedge clk);
    // inputs the dut sampled at this edge
    if (rst_n)
      step_model(buttons, crash, pea);
    buttons <= b;
    crash   <= c;
    pea     <= p;
    @(negedge clk);
    check_outputs();
  endtask

  task automatic apply_reset();
    repeat (9)
    begin
      @(posedge clk);
      @(negedge clk);
      check_outputs();
    end
    @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check_outputs();
  endtask

  task automatic press_and_wait(input flappy_pkg::buttons_t b,
                                input flappy_pkg::game_state_e target, input int limit);
    int n;
    n = 0;
    run_cycle(b, 1'b0, NO_PEA);
    while (state != target)
    begin
      if (n == limit)
      begin
        $display("timeout: state %s not reached within %0d cycles", target.name(), limit);
        stop_with_failure();
      end
      else
      begin
        run_cycle(NO_PRESS, 1'b0, NO_PEA);
        n++;
      end
    end
  endtask

  task automatic pulse_pea(input flappy_pkg::pea_kind_e kind);
    flappy_pkg::pea_event_t p;
    p.get  = 1'b1;
    p.kind = kind;
    run_cycle(NO_PRESS, 1'b0, p);
    run_cycle(NO_PRESS, 1'b0, NO_PEA);
  endtask

  // rare crashes and pickups, occasional mode buttons
  task automatic play_random(input int cycles, input logic allow_choose);
    flappy_pkg::buttons_t   b;
    flappy_pkg::pea_event_t p;
    logic [7:0]             r;
    logic                   c;
    for (int k = 0; k < cycles; k++)
    begin
      b = NO_PRESS;
      draw_bits(7, r);
      c = (r == 8'd0);
      draw_bits(4, r);
      p.get = (r == 8'd0);
      draw_bits(3, r);
      p.kind = flappy_pkg::pea_kind_e'(r[2:0]);
      if (allow_choose)
      begin
        draw_bits(6, r);
        b.choose1 = (r == 8'd0);
        draw_bits(6, r);
        b.choose2 = (r == 8'd1);
      end
      run_cycle(b, c, p);
    end
  endtask

  task automatic force_death(input int limit);
    int n;
    n = 0;
    while (state != flappy_pkg::DEAD)
    begin
      if (n == limit)
      begin
        $display("timeout: the game did not reach DEAD within %0d cycles", limit);
        stop_with_failure();
      end
      else
      begin
        // crash every other cycle, choose1 leaves cheat mode
        run_cycle(PRESS_C1, n[0], NO_PEA);
        n++;
      end
    end
  endtask

  initial
  begin
    rst_n      <= 1'b0;
    buttons    <= NO_PRESS;
    crash      <= 1'b0;
    pea        <= NO_PEA;
    lfsr       = 16'd12619;
    best_score = 0;
    reset_model();
    apply_reset();
    // first game, directed pickups before random play
    press_and_wait(PRESS_UP, flappy_pkg::NORMAL_MODE, 4);
    repeat (3) pulse_pea(flappy_pkg::PEA_WIDEN);
    repeat (5) pulse_pea(flappy_pkg::PEA_NARROW);
    pulse_pea(flappy_pkg::PEA_FAST);
    pulse_pea(flappy_pkg::PEA_SLOW);
    pulse_pea(flappy_pkg::PEA_FAST);
    repeat (12) pulse_pea(flappy_pkg::PEA_LIFE);
    press_and_wait(PRESS_C2, flappy_pkg::CHEAT_MODE, 4);
    run_cycle(NO_PRESS, 1'b1, NO_PEA);
    pulse_pea(flappy_pkg::PEA_HARM);
    press_and_wait(PRESS_C1, flappy_pkg::NORMAL_MODE, 4);
    play_random(2500, 1'b1);
    force_death(4000);
    best_score = exp_score;
    // lanes hold while dead
    play_random(100, 1'b0);
    press_and_wait(PRESS_ENTER, flappy_pkg::WELCOME, 4);
    // second game
    press_and_wait(PRESS_UP, flappy_pkg::NORMAL_MODE, 4);
    play_random(1500, 1'b1);
    force_death(4000);
    if (exp_score > best_score)
      best_score = exp_score;
    press_and_wait(PRESS_ENTER, flappy_pkg::WELCOME, 4);
    run_cycle(NO_PRESS, 1'b0, NO_PEA);
    run_cycle(NO_PRESS, 1'b0, NO_PEA);
    check_value("score.current", 32'(score.current), 32'h0);
    check_value("score.high", 32'(score.high), 32'(to_bcd(best_score)));
    $display(">>> PASS");
    $finish;
  end

endmodule

//--- design/flappy_control_top.sv
`timescale 1ns/1ns

module flappy_control_top (
  input  logic                     clk,
  input  logic                     rst_n,
  input  flappy_pkg::buttons_t     buttons,
  input  logic                     crash,
  input  flappy_pkg::pea_event_t   pea,
  output flappy_pkg::game_state_e  state,
  output logic                     intro_valid,
  output logic                     intro_type,
  output logic                     flash,
  output logic                     bird_visible,
  output logic [3:0]               life,
  output logic [9:0]               gap_width,
  output flappy_pkg::pillar_view_t pillar0,
  output flappy_pkg::pillar_view_t pillar1,
  output flappy_pkg::score_t       score
);

  logic [2:0] speed;
  logic       pass0;
  logic       pass1;

  //////////////////////////////
  // game flow
  //////////////////////////////
  game_fsm u_fsm (
    .clk(clk), .rst_n(rst_n), .buttons(buttons), .life(life),
    .state(state), .intro_valid(intro_valid), .intro_type(intro_type)
  );

  hit_tracker u_hit (
    .clk(clk), .rst_n(rst_n), .crash(crash), .pea(pea), .state(state),
    .life(life), .flash(flash), .bird_visible(bird_visible)
  );

  course_tuner u_course (
    .clk(clk), .rst_n(rst_n), .pea(pea), .state(state),
    .gap_width(gap_width), .speed(speed)
  );

  //////////////////////////////
  // pillars and score
  //////////////////////////////
  // lanes start staggered across the screen
  pillar_lane #(.START_H(9'd50)) u_lane0 (
    .clk(clk), .rst_n(rst_n), .state(state), .speed(speed), .view(pillar0), .pass(pass0)
  );

  pillar_lane #(.START_H(9'd224)) u_lane1 (
    .clk(clk), .rst_n(rst_n), .state(state), .speed(speed), .view(pillar1), .pass(pass1)
  );

  score_keeper #(.DIGITS(4)) u_score (
    .clk(clk), .rst_n(rst_n), .state(state), .pass0(pass0), .pass1(pass1), .score(score)
  );

endmodule

//--- design/score_keeper.sv
`timescale 1ns/1ns

module score_keeper #(
  parameter int DIGITS = 4
) (
  input  logic                    clk,
  input  logic                    rst_n,
  input  flappy_pkg::game_state_e state,
  input  logic                    pass0,
  input  logic                    pass1,
  output flappy_pkg::score_t      score
);

  logic [DIGITS-1:0][3:0] cur;
  logic [DIGITS-1:0][3:0] cur_inc;
  logic [DIGITS-1:0][3:0] high;
  logic                   carry;
  logic                   add;

  assign add = (pass0 || pass1)
               && ((state == flappy_pkg::NORMAL_MODE) || (state == flappy_pkg::CHEAT_MODE));

  //////////////////////////////
  // bcd increment
  //////////////////////////////
  always_comb
  begin
    carry   = 1'b1;
    cur_inc = cur;
    for (int i = 0; i < DIGITS; i++)
    begin
      if (carry)
      begin
        if (cur[i] == 4'd9)
        begin
          // roll over, carry ripples on
          cur_inc[i] = 4'd0;
        end
        else
        begin
          cur_inc[i] = cur[i] + 4'd1;
          carry      = 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      cur <= '0;
    else if (state == flappy_pkg::WELCOME)
      cur <= '0;
    else if (add)
      cur <= cur_inc;
  end

  // bcd digits compare correctly as a plain vector
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      high <= '0;
    else if (cur > high)
      high <= cur;
  end

  assign score.high    = high;
  assign score.current = cur;

endmodule

//--- design/pillar_lane.sv
`timescale 1ns/1ns

module pillar_lane #(
  parameter logic [8:0] START_H = 9'd50
) (
  input  logic                     clk,
  input  logic                     rst_n,
  input  flappy_pkg::game_state_e  state,
  input  logic [2:0]               speed,
  output flappy_pkg::pillar_view_t view,
  output logic                     pass
);

  logic       playing;
  logic       wrap;
  logic [8:0] step_h;

  assign playing = (state == flappy_pkg::NORMAL_MODE) || (state == flappy_pkg::CHEAT_MODE);
  // too close to the left edge for another step
  assign wrap    = view.h < 9'(speed);
  assign step_h  = view.h - 9'(speed);

  //////////////////////////////
  // position and valid
  //////////////////////////////
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      view <= '0;
    end
    else if (state == flappy_pkg::INITIAL_GAME)
    begin
      view.h     <= START_H;
      view.valid <= 1'b0;
    end
    else if (playing && wrap)
    begin
      view.h     <= flappy_pkg::RESPAWN_H;
      view.valid <= 1'b1;
    end
    else if (playing)
    begin
      view.h <= step_h;
    end
    else if (state == flappy_pkg::WELCOME)
    begin
      view.valid <= 1'b0;
    end
  end

  // pulse on the step that crosses the scoring point
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      pass <= 1'b0;
    else
      pass <= playing && view.valid
              && (view.h > flappy_pkg::SCORE_POINT)
              && (step_h <= flappy_pkg::SCORE_POINT);
  end

endmodule

//--- design/course_tuner.sv
`timescale 1ns/1ns

module course_tuner (
  input  logic                    clk,
  input  logic                    rst_n,
  input  flappy_pkg::pea_event_t  pea,
  input  flappy_pkg::game_state_e state,
  output logic [9:0]              gap_width,
  output logic [2:0]              speed
);

  //////////////////////////////
  // gap width
  //////////////////////////////
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      gap_width <= flappy_pkg::GAP_DEFAULT;
    else if (state == flappy_pkg::INITIAL_GAME)
      gap_width <= flappy_pkg::GAP_DEFAULT;
    else if (pea.get && pea.kind == flappy_pkg::PEA_WIDEN)
      gap_width <= (gap_width >= flappy_pkg::GAP_MAX - flappy_pkg::GAP_STEP) ?
                   flappy_pkg::GAP_MAX : gap_width + flappy_pkg::GAP_STEP;
    else if (pea.get && pea.kind == flappy_pkg::PEA_NARROW)
      gap_width <= (gap_width <= flappy_pkg::GAP_MIN + flappy_pkg::GAP_STEP) ?
                   flappy_pkg::GAP_MIN : gap_width - flappy_pkg::GAP_STEP;
  end

  //////////////////////////////
  // scroll speed
  //////////////////////////////
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      speed <= flappy_pkg::SPEED_DEFAULT;
    else if (state == flappy_pkg::INITIAL_GAME)
      speed <= flappy_pkg::SPEED_DEFAULT;
    else if (pea.get && pea.kind == flappy_pkg::PEA_FAST)
      speed <= flappy_pkg::SPEED_FAST;
    else if (pea.get && pea.kind == flappy_pkg::PEA_SLOW)
      speed <= flappy_pkg::SPEED_DEFAULT;
  end

endmodule

//--- design/hit_tracker.sv
`timescale 1ns/1ns

module hit_tracker (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    crash,
  input  flappy_pkg::pea_event_t  pea,
  input  flappy_pkg::game_state_e state,
  output logic [3:0]              life,
  output logic                    flash,
  output logic                    bird_visible
);

  logic [7:0] hit_timer;
  logic       hit_start;
  logic       life_pea;

  // a hit only counts while the timer is idle
  assign hit_start = (crash || (pea.get && pea.kind == flappy_pkg::PEA_HARM))
                     && (hit_timer == 8'd0) && (state != flappy_pkg::DEAD);
  assign life_pea  = pea.get && (pea.kind == flappy_pkg::PEA_LIFE);

  //////////////////////////////
  // hit timer
  //////////////////////////////
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      hit_timer <= 8'd0;
    else if (state == flappy_pkg::INITIAL_GAME)
      hit_timer <= 8'd0;
    else if (hit_start)
      hit_timer <= 8'd1;
    else if (hit_timer == flappy_pkg::HIT_LEN)
      hit_timer <= 8'd0;
    else if (hit_timer != 8'd0)
      hit_timer <= hit_timer + 8'd1;
  end

  //////////////////////////////
  // life count
  //////////////////////////////
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      life <= 4'd0;
    else if (state == flappy_pkg::INITIAL_GAME)
      life <= flappy_pkg::LIFE_START;
    else if (life_pea && life != flappy_pkg::LIFE_MAX)
      life <= life + 4'd1;
    else if (hit_start && state == flappy_pkg::NORMAL_MODE && life != 4'd0)
      life <= life - 4'd1;
  end

  // short flash at the start of a hit, then blink while recovering
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      flash        <= 1'b0;
      bird_visible <= 1'b1;
    end
    else
    begin
      flash        <= (hit_timer != 8'd0) && (hit_timer < flappy_pkg::FLASH_LEN);
      bird_visible <= !((hit_timer != 8'd0) && (state != flappy_pkg::DEAD)
                        && (hit_timer[4:3] == 2'b00));
    end
  end

endmodule

//--- design/game_fsm.sv
`timescale 1ns/1ns

module game_fsm (
  input  logic                   clk,
  input  logic                   rst_n,
  input  flappy_pkg::buttons_t   buttons,
  input  logic [3:0]             life,
  output flappy_pkg::game_state_e state,
  output logic                   intro_valid,
  output logic                   intro_type
);

  //////////////////////////////
  // state register
  //////////////////////////////
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state <= flappy_pkg::WELCOME;
    end
    else
    begin
      case (state)
        flappy_pkg::WELCOME:
        begin
          if (buttons.up)
            state <= flappy_pkg::INITIAL_GAME;
        end
        // one cycle of setup only
        flappy_pkg::INITIAL_GAME:
        begin
          state <= flappy_pkg::NORMAL_MODE;
        end
        flappy_pkg::NORMAL_MODE:
        begin
          if (buttons.choose2)
            state <= flappy_pkg::CHEAT_MODE;
          else if (life == 4'd0)
            state <= flappy_pkg::DEAD;
        end
        // no death check, cheat mode never loses life
        flappy_pkg::CHEAT_MODE:
        begin
          if (buttons.choose1)
            state <= flappy_pkg::NORMAL_MODE;
        end
        flappy_pkg::DEAD:
        begin
          if (buttons.enter)
            state <= flappy_pkg::WELCOME;
        end
        default:
        begin
          state <= flappy_pkg::WELCOME;
        end
      endcase
    end
  end

  // banner lags the state by one cycle
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      intro_valid <= 1'b0;
      intro_type  <= 1'b0;
    end
    else
    begin
      intro_valid <= (state == flappy_pkg::WELCOME) || (state == flappy_pkg::DEAD);
      intro_type  <= (state == flappy_pkg::DEAD);
    end
  end

endmodule

//--- design/flappy_pkg.sv
package flappy_pkg;

  //////////////////////////////
  // game states
  //////////////////////////////
  typedef enum logic [2:0] {
    WELCOME      = 3'd0,
    INITIAL_GAME = 3'd1,
    NORMAL_MODE  = 3'd2,
    CHEAT_MODE   = 3'd3,
    DEAD         = 3'd4
  } game_state_e;

  // pickup kinds, move and still are not used any more
  typedef enum logic [2:0] {
    PEA_MOVE   = 3'd0,
    PEA_HARM   = 3'd1,
    PEA_LIFE   = 3'd2,
    PEA_WIDEN  = 3'd3,
    PEA_STILL  = 3'd4,
    PEA_NARROW = 3'd5,
    PEA_FAST   = 3'd6,
    PEA_SLOW   = 3'd7
  } pea_kind_e;

  //////////////////////////////
  // bundles
  //////////////////////////////
  typedef struct packed {
    logic choose1;
    logic choose2;
    logic up;
    logic enter;
  } buttons_t;

  typedef struct packed {
    logic      get;
    pea_kind_e kind;
  } pea_event_t;

  typedef struct packed {
    logic       valid;
    logic [8:0] h;
  } pillar_view_t;

  // bcd digits, index 3 is the most significant
  typedef struct packed {
    logic [3:0][3:0] high;
    logic [3:0][3:0] current;
  } score_t;

  //////////////////////////////
  // game constants
  //////////////////////////////
  localparam logic [8:0] RESPAWN_H   = 9'd350;
  localparam logic [8:0] SCORE_POINT = 9'd100;

  localparam logic [9:0] GAP_DEFAULT = 10'd178;
  localparam logic [9:0] GAP_STEP    = 10'd50;
  localparam logic [9:0] GAP_MIN     = 10'd128;
  localparam logic [9:0] GAP_MAX     = 10'd228;

  localparam logic [2:0] SPEED_DEFAULT = 3'd2;
  localparam logic [2:0] SPEED_FAST    = 3'd3;

  localparam logic [3:0] LIFE_START = 4'd5;
  localparam logic [3:0] LIFE_MAX   = 4'd15;

  localparam logic [7:0] HIT_LEN   = 8'd200;
  localparam logic [7:0] FLASH_LEN = 8'd10;

endpackage
